// ==== common/dbg_pkg.sv ====
package dbg_pkg;

    localparam int DWORD      = 32;
    localparam int BYTE       = 8;
    localparam int NB_IM_ADDR = 5;   // 32 instruction words
    localparam int NB_RB_ADDR = 3;   // 8 registers
    localparam int NB_DM_ADDR = 3;   // 8 data words

    // Small baud divider so simulation stays short
    localparam int CLKS_PER_BIT = 8;
    localparam int NB_BAUD      = $clog2(CLKS_PER_BIT);
    localparam logic [NB_BAUD-1:0] BAUD_LAST = NB_BAUD'(CLKS_PER_BIT - 1);
    localparam logic [NB_BAUD-1:0] BAUD_MID  = NB_BAUD'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADDI = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_LW   = 4'h4,
        OP_SW   = 4'h5,
        OP_HALT = 4'h6
    } opcode_e;

    typedef struct packed {
        opcode_e                 opcode;
        logic                    pad_d;
        logic [NB_RB_ADDR-1:0]   rd;
        logic                    pad_s;
        logic [NB_RB_ADDR-1:0]   rs;
        logic                    pad_t;
        logic [NB_RB_ADDR-1:0]   rt;
        logic signed [15:0]      imm;
    } instr_t;

    // Host commands in ASCII
    typedef enum logic [7:0] {
        CMD_LOAD = 8'h4C,
        CMD_RUN  = 8'h52,
        CMD_STEP = 8'h53,
        CMD_DUMP = 8'h44
    } cmd_e;

    typedef enum logic [1:0] {
        SP_PC = 2'd0,
        SP_RB = 2'd1,
        SP_DM = 2'd2
    } space_e;

    typedef struct packed {
        space_e      space;
        logic [4:0]  idx;
    } dbg_req_t;

    localparam logic [BYTE-1:0] RSP_HALTED = 8'h48;   // ASCII H

endpackage

// ==== uart/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
    input  logic                     i_clock,
    input  logic                     i_rst,
    input  logic                     i_rx,
    output logic [dbg_pkg::BYTE-1:0] o_data,
    output logic                     o_done
);
    import dbg_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e          state;
    logic [NB_BAUD-1:0] cnt;
    logic [2:0]         bit_idx;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!i_rx)
                        state <= RX_START;
                end
                RX_START: begin
                    if (cnt == BAUD_MID) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= i_rx ? RX_IDLE : RX_DATA;  // Reject a glitch
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BAUD_LAST) begin
                        cnt     <= '0;
                        o_data  <= {i_rx, o_data[BYTE-1:1]};  // LSB arrives first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == BAUD_LAST) begin
                        o_done <= 1'b1;
                        state  <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    a_done_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
        o_done |=> !o_done) else $error("rx done held longer than one cycle");

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input  logic                     i_clock,
    input  logic                     i_rst,
    input  logic [dbg_pkg::BYTE-1:0] i_data,
    input  logic                     i_start,
    output logic                     o_tx,
    output logic                     o_busy,
    output logic                     o_done
);
    import dbg_pkg::*;

    logic [BYTE-1:0]    shreg;
    logic [NB_BAUD-1:0] cnt;
    logic [3:0]         bit_cnt;   // 0 start, 1 to 8 data, 9 stop

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_tx    <= 1'b1;
            o_busy  <= 1'b0;
            o_done  <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
        end else begin
            o_done <= 1'b0;
            if (!o_busy) begin
                if (i_start) begin
                    shreg   <= i_data;
                    o_tx    <= 1'b0;
                    o_busy  <= 1'b1;
                    cnt     <= '0;
                    bit_cnt <= '0;
                end
            end else if (cnt != BAUD_LAST) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt     <= '0;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd9) begin
                    o_busy <= 1'b0;   // End of stop bit
                    o_done <= 1'b1;
                end else if (bit_cnt == 4'd8) begin
                    o_tx <= 1'b1;
                end else begin
                    o_tx  <= shreg[0];
                    shreg <= shreg >> 1;
                end
            end
        end
    end

    a_no_start_busy: assert property (@(posedge i_clock) disable iff (i_rst)
        i_start |-> !o_busy) else $error("tx start while busy");

endmodule

// ==== debug_unit/debug_unit.sv ====
`timescale 1ns/100ps

module debug_unit (
    input  logic                           i_clock,
    input  logic                           i_rst,
    input  logic [dbg_pkg::BYTE-1:0]       i_rx_data,
    input  logic                           i_rx_done,
    output logic [dbg_pkg::BYTE-1:0]       o_tx_data,
    output logic                           o_tx_start,
    input  logic                           i_tx_busy,
    input  logic                           i_tx_done,
    input  logic                           i_hlt,
    output logic                           o_im_we,
    output logic [dbg_pkg::NB_IM_ADDR-1:0] o_im_addr,
    output dbg_pkg::instr_t                o_im_data,
    output logic                           o_exec,
    output logic                           o_dbg_req,
    output dbg_pkg::dbg_req_t              o_dbg_sel,
    input  logic                           i_dbg_ack,
    input  logic [dbg_pkg::DWORD-1:0]      i_dbg_data
);
    import dbg_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE, ST_LOAD_N, ST_LOAD_B, ST_RUN, ST_STEP, ST_REQ, ST_REL, ST_SEND, ST_WAIT
    } state_e;

    state_e            state;
    logic [DWORD-1:0]  word;        // Load assembly, then tx serializer
    logic [1:0]        byte_cnt;
    logic [2:0]        bytes_left;
    logic [BYTE-1:0]   words_left;
    logic              dump;
    logic              last_sel;
    dbg_req_t          next_sel;

    assign o_im_data = instr_t'(word);

    // Dump order is PC, r0 to r7, then dm 0 to 7
    always_comb begin
        next_sel     = o_dbg_sel;
        next_sel.idx = o_dbg_sel.idx + 1'b1;
        if (o_dbg_sel.space == SP_PC) begin
            next_sel = '{SP_RB, '0};
        end else if (o_dbg_sel.idx == 5'd7) begin
            next_sel = '{SP_DM, '0};
        end
    end

    assign last_sel = (o_dbg_sel.space == SP_DM) && (o_dbg_sel.idx == 5'd7);

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state      <= ST_IDLE;
            o_exec     <= 1'b0;
            o_im_we    <= 1'b0;
            o_im_addr  <= '0;
            o_tx_start <= 1'b0;
            o_dbg_req  <= 1'b0;
            o_dbg_sel  <= '{SP_PC, '0};
            byte_cnt   <= '0;
            bytes_left <= '0;
            words_left <= '0;
            dump       <= 1'b0;
        end else begin
            o_exec     <= 1'b0;
            o_im_we    <= 1'b0;
            o_tx_start <= 1'b0;
            if (o_im_we)
                o_im_addr <= o_im_addr + 1'b1;
            case (state)
                ST_IDLE: if (i_rx_done) begin
                    case (cmd_e'(i_rx_data))
                        CMD_LOAD: state <= ST_LOAD_N;
                        CMD_RUN:  state <= ST_RUN;
                        CMD_STEP: begin
                            o_exec <= 1'b1;
                            dump   <= 1'b0;
                            state  <= ST_STEP;
                        end
                        CMD_DUMP: begin
                            o_dbg_req <= 1'b1;
                            o_dbg_sel <= '{SP_PC, '0};
                            dump      <= 1'b1;
                            state     <= ST_REQ;
                        end
                        default: ;   // Unknown byte, dropped
                    endcase
                end
                ST_LOAD_N: if (i_rx_done) begin
                    words_left <= i_rx_data;
                    o_im_addr  <= '0;
                    byte_cnt   <= '0;
                    state      <= (i_rx_data == '0) ? ST_IDLE : ST_LOAD_B;
                end
                ST_LOAD_B: if (i_rx_done) begin
                    word     <= {i_rx_data, word[DWORD-1:BYTE]};   // LSB first
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'd3) begin
                        o_im_we    <= 1'b1;
                        words_left <= words_left - 1'b1;
                        if (words_left == 8'd1)
                            state <= ST_IDLE;
                    end
                end
                ST_RUN: begin
                    if (i_hlt) begin
                        word       <= DWORD'(RSP_HALTED);
                        bytes_left <= 3'd1;
                        dump       <= 1'b0;
                        state      <= ST_SEND;
                    end else begin
                        o_exec <= 1'b1;
                    end
                end
                ST_STEP: begin   // Exec is high this cycle, PC settles before the read
                    o_dbg_req <= 1'b1;
                    o_dbg_sel <= '{SP_PC, '0};
                    state     <= ST_REQ;
                end
                ST_REQ: if (i_dbg_ack) begin
                    word       <= i_dbg_data;
                    bytes_left <= dump ? 3'd4 : 3'd1;
                    o_dbg_req  <= 1'b0;
                    state      <= ST_REL;
                end
                ST_REL: if (!i_dbg_ack)
                    state <= ST_SEND;
                ST_SEND: if (!i_tx_busy) begin
                    o_tx_data  <= word[BYTE-1:0];
                    o_tx_start <= 1'b1;
                    word       <= word >> BYTE;
                    state      <= ST_WAIT;
                end
                ST_WAIT: if (i_tx_done) begin
                    bytes_left <= bytes_left - 1'b1;
                    if (bytes_left != 3'd1) begin
                        state <= ST_SEND;
                    end else if (dump && !last_sel) begin
                        o_dbg_sel <= next_sel;
                        o_dbg_req <= 1'b1;
                        state     <= ST_REQ;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_sel_stable: assert property (@(posedge i_clock) disable iff (i_rst)
        o_dbg_req && $past(o_dbg_req) |-> $stable(o_dbg_sel))
        else $error("debug select changed during a pending request");

    a_we_exec: assert property (@(posedge i_clock) disable iff (i_rst)
        !(o_im_we && o_exec)) else $error("imem write while executing");

endmodule

// ==== rtl/data_path.sv ====
`timescale 1ns/100ps

module data_path (
    input  logic                           i_clock,
    input  logic                           i_rst,
    input  logic                           i_im_we,
    input  logic [dbg_pkg::NB_IM_ADDR-1:0] i_im_addr,
    input  dbg_pkg::instr_t                i_im_data,
    input  logic                           i_exec,
    input  logic                           i_dbg_req,
    input  dbg_pkg::dbg_req_t              i_dbg_sel,
    output logic                           o_dbg_ack,
    output logic [dbg_pkg::DWORD-1:0]      o_dbg_data,
    output logic                           o_hlt
);
    import dbg_pkg::*;

    instr_t                 imem [2**NB_IM_ADDR];
    logic [DWORD-1:0]       rb   [2**NB_RB_ADDR];
    logic [DWORD-1:0]       dm   [2**NB_DM_ADDR];
    logic [NB_IM_ADDR-1:0]  pc;

    instr_t                 instr;
    logic [DWORD-1:0]       rs_val;
    logic [DWORD-1:0]       rt_val;
    logic [DWORD-1:0]       imm_ext;
    logic [DWORD-1:0]       alu_res;
    logic [NB_DM_ADDR-1:0]  dm_addr;
    logic                   wb_en;
    logic [DWORD-1:0]       wb_data;
    logic                   step;
    logic [DWORD-1:0]       dbg_mux;

    assign step    = i_exec && !o_hlt;
    assign instr   = imem[pc];
    assign rs_val  = rb[instr.rs];
    assign rt_val  = rb[instr.rt];
    assign imm_ext = {{(DWORD-16){instr.imm[15]}}, instr.imm};
    assign dm_addr = alu_res[NB_DM_ADDR-1:0];

    always_comb begin
        case (instr.opcode)
            OP_ADD:  alu_res = rs_val + rt_val;
            OP_SUB:  alu_res = rs_val - rt_val;
            default: alu_res = rs_val + imm_ext;   // ADDI and load/store address
        endcase
    end

    always_comb begin
        wb_en   = 1'b0;
        wb_data = alu_res;
        case (instr.opcode)
            OP_ADDI, OP_ADD, OP_SUB: wb_en = 1'b1;
            OP_LW: begin
                wb_en   = 1'b1;
                wb_data = dm[dm_addr];
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_im_we)
            imem[i_im_addr] <= i_im_data;
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc    <= '0;
            o_hlt <= 1'b0;
            for (int i = 0; i < 2**NB_RB_ADDR; i++)
                rb[i] <= '0;
            for (int i = 0; i < 2**NB_DM_ADDR; i++)
                dm[i] <= '0;
        end else if (step) begin
            if (instr.opcode == OP_HALT) begin
                o_hlt <= 1'b1;   // PC stays on the HALT
            end else begin
                pc <= pc + 1'b1;
            end
            if (wb_en && instr.rd != '0)   // r0 is never written
                rb[instr.rd] <= wb_data;
            if (instr.opcode == OP_SW)
                dm[dm_addr] <= rt_val;
        end
    end

    always_comb begin
        case (i_dbg_sel.space)
            SP_PC:   dbg_mux = {{(DWORD-NB_IM_ADDR){1'b0}}, pc};
            SP_RB:   dbg_mux = rb[i_dbg_sel.idx[NB_RB_ADDR-1:0]];
            SP_DM:   dbg_mux = dm[i_dbg_sel.idx[NB_DM_ADDR-1:0]];
            default: dbg_mux = '0;
        endcase
    end

    // Four-phase handshake, ack one cycle after req
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_dbg_ack <= 1'b0;
        end else if (i_dbg_req && !o_dbg_ack) begin
            o_dbg_ack <= 1'b1;
        end else if (!i_dbg_req) begin
            o_dbg_ack <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_dbg_req && !o_dbg_ack)
            o_dbg_data <= dbg_mux;
    end

    a_hlt_sticky: assert property (@(posedge i_clock)
        (o_hlt && !i_rst) |=> o_hlt) else $error("halt flag fell without reset");

endmodule

// ==== rtl/top.sv ====
`timescale 1ns/100ps

module top (
    input  logic i_clock,
    input  logic i_rst,
    input  logic i_uart_rx,
    output logic o_uart_tx,
    output logic o_hlt
);
    import dbg_pkg::*;

    logic [BYTE-1:0]        rx_data;
    logic                   rx_done;
    logic [BYTE-1:0]        tx_data;
    logic                   tx_start;
    logic                   tx_busy;
    logic                   tx_done;
    logic                   im_we;
    logic [NB_IM_ADDR-1:0]  im_addr;
    instr_t                 im_data;
    logic                   exec;
    logic                   dbg_req;
    dbg_req_t               dbg_sel;
    logic                   dbg_ack;
    logic [DWORD-1:0]       dbg_data;

    uart_rx uart_rx_1 (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_rx    (i_uart_rx),
        .o_data  (rx_data),
        .o_done  (rx_done)
    );

    uart_tx uart_tx_1 (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_data  (tx_data),
        .i_start (tx_start),
        .o_tx    (o_uart_tx),
        .o_busy  (tx_busy),
        .o_done  (tx_done)
    );

    debug_unit debug_unit_1 (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_rx_data  (rx_data),
        .i_rx_done  (rx_done),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start),
        .i_tx_busy  (tx_busy),
        .i_tx_done  (tx_done),
        .i_hlt      (o_hlt),
        .o_im_we    (im_we),
        .o_im_addr  (im_addr),
        .o_im_data  (im_data),
        .o_exec     (exec),
        .o_dbg_req  (dbg_req),
        .o_dbg_sel  (dbg_sel),
        .i_dbg_ack  (dbg_ack),
        .i_dbg_data (dbg_data)
    );

    data_path data_path_1 (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_im_we    (im_we),
        .i_im_addr  (im_addr),
        .i_im_data  (im_data),
        .i_exec     (exec),
        .i_dbg_req  (dbg_req),
        .i_dbg_sel  (dbg_sel),
        .o_dbg_ack  (dbg_ack),
        .o_dbg_data (dbg_data),
        .o_hlt      (o_hlt)
    );

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;
    import dbg_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int BIT_NS      = CLKS_PER_BIT * CLK_NS;
    localparam int IM_WORDS    = 2**NB_IM_ADDR;
    localparam int RB_WORDS    = 2**NB_RB_ADDR;
    localparam int DM_WORDS    = 2**NB_DM_ADDR;
    localparam int DUMP_WORDS  = 1 + RB_WORDS + DM_WORDS;
    localparam int MAX_STEPS   = 40;
    localparam int QUIET_BYTES = 3;
    localparam int LOAD_BYTES  = 2 + 4 * IM_WORDS;
    localparam int DUMP_BYTES  = 1 + 4 * DUMP_WORDS;
    // Six dumps, three loads, steps and runs with their replies, one stray byte
    localparam int TOTAL_BYTES = 6 * DUMP_BYTES + 3 * LOAD_BYTES + 2 * (MAX_STEPS + 2)
                               + 3 * 2 + 1 + QUIET_BYTES;
    localparam int WATCHDOG_NS = (TOTAL_BYTES * 10 * BIT_NS) * 5 / 4 + 20000;

    logic i_clock = 1'b0;
    logic i_rst;
    logic i_uart_rx;
    logic o_uart_tx;
    logic o_hlt;

    logic [BYTE-1:0]  rx_q [$];
    instr_t           prog [IM_WORDS];
    logic [DWORD-1:0] dump_words [DUMP_WORDS];

    // Reference model state
    instr_t           m_imem [IM_WORDS];
    int               m_pc;
    logic             m_hlt;
    logic [DWORD-1:0] m_rb [RB_WORDS];
    logic [DWORD-1:0] m_dm [DM_WORDS];

    opcode_e plain_ops [6] = '{OP_NOP, OP_ADDI, OP_ADD, OP_SUB, OP_LW, OP_SW};

    top UUT (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_uart_rx (i_uart_rx),
        .o_uart_tx (o_uart_tx),
        .o_hlt     (o_hlt)
    );

    always #(CLK_NS / 2) i_clock = ~i_clock;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [BYTE-1:0] exp,
                              input logic [BYTE-1:0] act);
        if (act !== exp)
            stop_with_error($sformatf("MISMATCH %s expected %02h actual %02h", name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [DWORD-1:0] exp,
                              input logic [DWORD-1:0] act);
        if (act !== exp)
            stop_with_error($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_with_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    task automatic apply_reset();
        @(posedge i_clock);
        i_rst <= 1'b1;
        repeat (3) @(posedge i_clock);
        i_rst <= 1'b0;
        m_pc  = 0;
        m_hlt = 1'b0;
        for (int i = 0; i < RB_WORDS; i++)
            m_rb[i] = '0;
        for (int i = 0; i < DM_WORDS; i++)
            m_dm[i] = '0;
        rx_q.delete();
        @(negedge i_clock);
    endtask

    // 8N1 frame with one bit every CLKS_PER_BIT clocks
    task automatic send_byte(input logic [BYTE-1:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clock);
            i_uart_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge i_clock);
        end
    endtask

    task automatic recv_byte(output logic [BYTE-1:0] b);
        while (rx_q.size() == 0)
            @(negedge i_clock);
        b = rx_q.pop_front();
    endtask

    task automatic load_program();
        logic [DWORD-1:0] bits;
        send_byte(CMD_LOAD);
        send_byte(8'(IM_WORDS));
        for (int w = 0; w < IM_WORDS; w++) begin
            bits = prog[w];
            for (int k = 0; k < 4; k++)
                send_byte(bits[8*k +: 8]);   // LSB first
            m_imem[w] = prog[w];
        end
    endtask

    // No HALT anywhere unless halt_slot is a valid address
    task automatic random_program(input int halt_slot);
        for (int w = 0; w < IM_WORDS; w++) begin
            prog[w]        = instr_t'($urandom);
            prog[w].opcode = plain_ops[$urandom_range(5, 0)];
        end
        if (halt_slot >= 0)
            prog[halt_slot].opcode = OP_HALT;
    endtask

    task automatic write_reg(input logic [NB_RB_ADDR-1:0] idx, input logic [DWORD-1:0] val);
        if (idx != 0)
            m_rb[idx] = val;
    endtask

    task automatic execute_model();
        instr_t           ins;
        logic [DWORD-1:0] a;
        logic [DWORD-1:0] b;
        logic [DWORD-1:0] sum_imm;
        int               dm_idx;
        if (m_hlt)
            return;
        ins     = m_imem[m_pc];
        a       = m_rb[ins.rs];
        b       = m_rb[ins.rt];
        sum_imm = a + DWORD'(int'(ins.imm));   // imm is signed
        dm_idx  = int'(sum_imm % DM_WORDS);
        case (ins.opcode)
            OP_ADDI: write_reg(ins.rd, sum_imm);
            OP_ADD:  write_reg(ins.rd, a + b);
            OP_SUB:  write_reg(ins.rd, a - b);
            OP_LW:   write_reg(ins.rd, m_dm[dm_idx]);
            OP_SW:   m_dm[dm_idx] = b;
            OP_HALT: m_hlt = 1'b1;
            default: ;
        endcase
        if (ins.opcode != OP_HALT)
            m_pc = (m_pc + 1) % IM_WORDS;
    endtask

    task automatic check_dump(input string name);
        logic [BYTE-1:0] b;
        if (rx_q.size() != 0)
            stop_with_error($sformatf("%s: reply bytes arrived before DUMP was sent", name));
        send_byte(CMD_DUMP);
        for (int w = 0; w < DUMP_WORDS; w++) begin
            dump_words[w] = '0;
            for (int k = 0; k < 4; k++) begin
                recv_byte(b);
                dump_words[w][8*k +: 8] = b;
            end
        end
        check_word({name, " pc"}, DWORD'(m_pc), dump_words[0]);
        for (int r = 0; r < RB_WORDS; r++)
            check_word($sformatf("%s r%0d", name, r), m_rb[r], dump_words[1 + r]);
        for (int d = 0; d < DM_WORDS; d++)
            check_word($sformatf("%s dm%0d", name, d), m_dm[d], dump_words[1 + RB_WORDS + d]);
    endtask

    // Samples o_uart_tx on falling edges away from its updates
    initial begin : uart_monitor
        logic [BYTE-1:0] bits;
        forever begin
            @(negedge i_clock);
            if (i_rst === 1'b0 && o_uart_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge i_clock);
                for (int i = 0; i < BYTE; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge i_clock);
                    bits[i] = o_uart_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge i_clock);
                if (o_uart_tx !== 1'b1)
                    stop_with_error("Stop bit on o_uart_tx was not high");
                rx_q.push_back(bits);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_with_error($sformatf("Timeout: tests did not finish within %0d ns", WATCHDOG_NS));
    end

    initial begin : main
        logic [BYTE-1:0] b;
        int              n_steps;
        int              halt_slot;
        i_rst     <= 1'b1;
        i_uart_rx <= 1'b1;
        void'($urandom(94));
        apply_reset();

        // Test 1 with a clean state after reset
        check_bit("reset hlt", 1'b0, o_hlt);
        check_dump("reset dump");

        // Test 2 steps a random program
        random_program(-1);
        load_program();
        n_steps = $urandom_range(MAX_STEPS, 1);
        for (int i = 0; i < n_steps; i++) begin
            send_byte(CMD_STEP);
            execute_model();
            recv_byte(b);
            check_byte($sformatf("step %0d pc", i), 8'(m_pc), b);
        end
        check_dump("step dump");

        // Test 3 runs up to a HALT
        apply_reset();
        halt_slot = $urandom_range(IM_WORDS - 1, 4);
        random_program(halt_slot);
        load_program();
        send_byte(CMD_RUN);
        while (!m_hlt)
            execute_model();
        recv_byte(b);
        check_byte("run reply", RSP_HALTED, b);
        @(negedge i_clock);
        check_bit("run hlt", 1'b1, o_hlt);
        check_dump("run dump");
        send_byte(CMD_STEP);   // PC must not move while halted
        execute_model();
        recv_byte(b);
        check_byte("step while halted", 8'(halt_slot), b);
        send_byte(CMD_RUN);
        recv_byte(b);
        check_byte("run while halted", RSP_HALTED, b);

        // Test 4 moves data through data memory
        apply_reset();
        for (int w = 0; w < IM_WORDS; w++)
            prog[w] = '{opcode: OP_NOP, default: '0};
        for (int r = 0; r < RB_WORDS - 1; r++) begin
            prog[r]        = instr_t'($urandom);
            prog[r].opcode = OP_ADDI;
            prog[r].rd     = NB_RB_ADDR'(r + 1);
            prog[r].rs     = '0;
        end
        for (int w = RB_WORDS - 1; w < 23; w++) begin
            prog[w]        = instr_t'($urandom);
            prog[w].opcode = ($urandom_range(1, 0) == 1) ? OP_SW : OP_LW;
        end
        prog[23]        = instr_t'($urandom);
        prog[23].opcode = OP_LW;
        prog[23].rd     = '0;   // Load aimed at r0
        prog[24].opcode = OP_HALT;
        load_program();
        send_byte(CMD_RUN);
        while (!m_hlt)
            execute_model();
        recv_byte(b);
        check_byte("memory run reply", RSP_HALTED, b);
        check_dump("memory dump");

        // Test 5 resets again and sends a stray byte before a normal STEP
        apply_reset();
        check_bit("second reset hlt", 1'b0, o_hlt);
        check_dump("second reset dump");
        send_byte(8'h5A);
        repeat (QUIET_BYTES * 10 * CLKS_PER_BIT) @(posedge i_clock);
        if (rx_q.size() != 0)
            stop_with_error("Unknown command byte produced a reply");
        send_byte(CMD_STEP);
        execute_model();
        recv_byte(b);
        check_byte("step after unknown", 8'(m_pc), b);
        check_dump("final dump");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
common/dbg_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
debug_unit/debug_unit.sv
rtl/data_path.sv
rtl/top.sv
tests/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build tb_top with Verilator, run it, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_top -f project.f -o tb_top_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_top_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
